// File: vlog.f
+incdir+logic
logic/vp_pkg.sv
logic/clk_enable_gen.sv
logic/cart_store.sv
logic/input_encoder.sv
logic/palette_map.sv
logic/vp_glue_top.sv
tb/vp_glue_tb.sv

// File: tb/vp_glue_tb.sv
// Drives vp_glue_top through all glue functions; a cycle watchdog bounds the run
`default_nettype none

`include "vp_cfg.svh"

module vp_glue_tb;

	import vp_pkg::*;

	logic       clk_sys;
	logic       reset;
	logic       pal_i;
	logic       pal_palette_i;
	logic       mono_i;
	logic       joy_swap_i;
	dl_bus_t    dl;
	cart_bus_t  cart;
	logic [15:0] joy0;
	logic [15:0] joy1;
	logic [10:0] ps2_key;
	pix_code_t  pix;
	logic       cpu_en;
	logic       vdc_en;
	byte_t      rom_data;
	joy_lines_t joy_lines;
	key_evt_t   key_evt;
	rgb24_t     rgb;
	logic       console_res_n;

	byte_t  shadow [`VP_ROM_DEPTH]; // Expected cartridge contents
	integer seed = 32'h291b;
	int     errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     e;
	rgb24_t c8n;
	rgb24_t c8p;

	vp_glue_top dut_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.pal_i           (pal_i),
		.pal_palette_i   (pal_palette_i),
		.mono_i          (mono_i),
		.joy_swap_i      (joy_swap_i),
		.dl_i            (dl),
		.cart_i          (cart),
		.joy0_i          (joy0),
		.joy1_i          (joy1),
		.ps2_key_i       (ps2_key),
		.pix_i           (pix),
		.cpu_en_o        (cpu_en),
		.vdc_en_o        (vdc_en),
		.rom_data_o      (rom_data),
		.joy_o           (joy_lines),
		.key_evt_o       (key_evt),
		.rgb_o           (rgb),
		.console_res_n_o (console_res_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Watchdog for the whole run
	initial begin
		repeat (200000) @(posedge clk_sys);
		$display("timeout: simulation did not finish within 200000 cycles");
		$display("Test FAILED");
		$finish;
	end

	// Console reset follows reset, download and both pad reset buttons
	assert property (@(posedge clk_sys)
		console_res_n == !(reset || dl.active || joy0[5] || joy1[5]))
	else begin
		$display("error at time %0t: console_res_n_o is %b, expected %b", $time,
			$sampled(console_res_n), !$sampled(reset || dl.active || joy0[5] || joy1[5]));
		errors++;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		errors++;
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic measure_gap(input bit use_vdc, input int expected, input string name);
		int n;
		bit seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < 32) begin
			@(negedge clk_sys);
			n++;
			seen = use_vdc ? vdc_en : cpu_en;
		end
		assert (seen) else begin
			$display("%s never pulsed within 32 cycles", name);
			errors++;
		end
		if (seen) begin
			n = 0;
			seen = 1'b0;
			while (!seen && n < 32) begin // Cycles to the next pulse
				@(negedge clk_sys);
				n++;
				seen = use_vdc ? vdc_en : cpu_en;
			end
			assert (n == expected) else report_mismatch({name, " period"}, n, expected);
		end
	endtask

	function automatic rom_addr_t expected_addr(input map_mode_t mode, input cart_addr_t a,
		input logic bs0, input logic bs1);
		case (mode)
			MAP_XROM: return rom_addr_t'(a);
			MAP_4K:   return rom_addr_t'({bs0, a[11], a[9:0]});
			MAP_8K:   return rom_addr_t'({bs1, bs0, a[11], a[9:0]});
			MAP_16K:  return {bs1, bs0, a};
			default:  return rom_addr_t'({a[11], a[9:0]});
		endcase
	endfunction

	task automatic load_image(input dl_index_t idx, input int size);
		logic [31:0] r;
		@(posedge clk_sys);
		dl.active <= 1'b1;
		dl.index  <= idx;
		dl.wr     <= 1'b0;
		for (int i = 0; i < size; i++) begin
			r = $random(seed);
			@(posedge clk_sys);
			dl.wr   <= 1'b1;
			dl.data <= r[7:0];
			if (idx < `VP_IDX_FONT) begin
				shadow[i] = r[7:0];
			end
		end
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(negedge clk_sys);
		assert (console_res_n == 1'b0) else report_mismatch("console_res_n_o", 1, 0);
		@(posedge clk_sys);
		dl.active <= 1'b0;
	endtask

	task automatic read_and_compare(input map_mode_t mode, input cart_addr_t a,
		input logic bs0, input logic bs1);
		rom_addr_t ra;
		ra = expected_addr(mode, a, bs0, bs1);
		@(posedge clk_sys);
		cart.addr   <= a;
		cart.bs0    <= bs0;
		cart.bs1    <= bs1;
		cart.psen_n <= 1'b0;
		@(posedge clk_sys);
		cart.psen_n <= 1'b1;
		@(negedge clk_sys);
		assert (rom_data == shadow[ra]) else
			report_mismatch("rom_data_o", rom_data, shadow[ra]);
	endtask

	task automatic test_mapping(input dl_index_t idx, input int size, input map_mode_t mode);
		logic [31:0] r;
		byte_t held;
		if (size > 0) begin
			load_image(idx, size);
		end
		read_and_compare(mode, 12'h000, 1'b0, 1'b0);
		read_and_compare(mode, 12'hFFF, 1'b1, 1'b1);
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			read_and_compare(mode, r[11:0], r[12], r[13]);
		end
		held = rom_data;
		@(posedge clk_sys);
		cart.addr <= ~cart.addr; // Output must hold while PSEN is high
		@(posedge clk_sys);
		@(negedge clk_sys);
		assert (rom_data == held) else report_mismatch("rom_data_o hold", rom_data, held);
	endtask

	task automatic wait_key_event(output key_evt_t evt, output bit seen);
		int n;
		n = 0;
		seen = 1'b0;
		evt = '0;
		while (!seen && n < 8) begin
			@(negedge clk_sys);
			n++;
			if (key_evt.strobe) begin
				seen = 1'b1;
				evt = key_evt;
			end
		end
		assert (seen) else begin
			$display("no key event strobe within 8 cycles at time %0t", $time);
			errors++;
		end
		repeat (3) begin
			@(negedge clk_sys);
			assert (!key_evt.strobe) else report_mismatch("key_evt_o.strobe", 1, 0);
		end
	endtask

	task automatic key_scan(input byte_t code, input logic pressed, input byte_t exp_ascii,
		input logic [9:0] pad_bits);
		key_evt_t evt;
		bit seen;
		@(posedge clk_sys);
		ps2_key <= {~ps2_key[10], pressed, 1'b0, code};
		joy0    <= {pad_bits, 6'b0}; // Simultaneous numpad change when nonzero
		wait_key_event(evt, seen);
		if (seen) begin
			assert (evt.ascii == exp_ascii) else report_mismatch("key_evt_o.ascii", evt.ascii,
				exp_ascii);
			assert (evt.released == !pressed) else report_mismatch("key_evt_o.released",
				evt.released, !pressed);
		end
	endtask

	task automatic key_pad(input logic [9:0] bits0, input logic [9:0] bits1,
		input byte_t exp_ascii);
		key_evt_t evt;
		bit seen;
		logic rel;
		rel = (bits0 | bits1) == 10'd0;
		@(posedge clk_sys);
		joy0 <= {bits0, 6'b0};
		joy1 <= {bits1, 6'b0};
		wait_key_event(evt, seen);
		if (seen) begin
			if (!rel) begin
				assert (evt.ascii == exp_ascii) else report_mismatch("key_evt_o.ascii",
					evt.ascii, exp_ascii);
			end
			assert (evt.released == rel) else report_mismatch("key_evt_o.released",
				evt.released, rel);
		end
	endtask

	function automatic rgb24_t grey_of(input rgb24_t c);
		int y;
		y = (77 * c.r + 150 * c.g + 29 * c.b) / 256;
		return {y[7:0], y[7:0], y[7:0]};
	endfunction

	task automatic colour_check(input logic [3:0] code, input logic pal_sel, input logic mono,
		input rgb24_t exp_colour);
		rgb24_t exp;
		exp = mono ? grey_of(exp_colour) : exp_colour;
		@(posedge clk_sys);
		pix           <= code;
		pal_palette_i <= pal_sel;
		mono_i        <= mono;
		@(posedge clk_sys);
		@(negedge clk_sys);
		assert (rgb == exp) else report_mismatch("rgb_o", rgb, exp);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		reset         = 1'b1;
		pal_i         = 1'b0;
		pal_palette_i = 1'b0;
		mono_i        = 1'b0;
		joy_swap_i    = 1'b0;
		dl            = '0;
		cart          = '0;
		cart.psen_n   = 1'b1;
		cart.cs_n     = 1'b1;
		joy0          = 16'h0000;
		joy1          = 16'h0000;
		ps2_key       = 11'h000;
		pix           = '0;

		e = errors;
		repeat (9) @(posedge clk_sys);
		@(negedge clk_sys);
		assert (console_res_n == 1'b0) else report_mismatch("console_res_n_o", 1, 0);
		assert (!cpu_en && !vdc_en) else
			report_mismatch("{cpu_en_o, vdc_en_o}", {cpu_en, vdc_en}, 0);
		assert (!key_evt.strobe) else report_mismatch("key_evt_o.strobe", 1, 0);
		assert (rgb == 24'h0) else report_mismatch("rgb_o", rgb, 0);
		@(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		assert (!cpu_en && !vdc_en) else
			report_mismatch("{cpu_en_o, vdc_en_o}", {cpu_en, vdc_en}, 0);
		end_test("reset state", e);

		e = errors;
		measure_gap(1'b0, `VP_CPU_DIV_NTSC, "cpu_en_o");
		measure_gap(1'b1, `VP_VDC_DIV_NTSC, "vdc_en_o");
		@(posedge clk_sys);
		pal_i <= 1'b1;
		measure_gap(1'b0, `VP_CPU_DIV_PAL, "cpu_en_o");
		measure_gap(1'b1, `VP_VDC_DIV_PAL, "vdc_en_o");
		end_test("enable periods", e);

		e = errors;
		test_mapping(8'd0, 16384, MAP_16K);
		test_mapping(8'd1, 8192, MAP_8K);
		test_mapping(8'd0, 4096, MAP_4K);
		test_mapping(8'd0, 2048, MAP_2K);
		test_mapping(`VP_IDX_XROM, 4096, MAP_XROM);
		load_image(`VP_IDX_FONT, 512); // Font bytes are dropped and the size returns to zero
		test_mapping(8'd0, 0, MAP_2K);
		end_test("cartridge mappings", e);

		e = errors;
		@(posedge clk_sys);
		joy0[5] <= 1'b1;
		@(negedge clk_sys);
		assert (console_res_n == 1'b0) else report_mismatch("console_res_n_o", 1, 0);
		@(posedge clk_sys);
		joy0[5] <= 1'b0;
		joy1[5] <= 1'b1;
		@(negedge clk_sys);
		assert (console_res_n == 1'b0) else report_mismatch("console_res_n_o", 1, 0);
		@(posedge clk_sys);
		joy1[5] <= 1'b0;
		@(negedge clk_sys);
		assert (console_res_n == 1'b1) else report_mismatch("console_res_n_o", 0, 1);
		end_test("console reset", e);

		e = errors;
		key_scan(8'h1C, 1'b1, "a", 10'd0);
		key_scan(8'h1C, 1'b0, "a", 10'd0);
		key_scan(8'h5A, 1'b1, 8'd10, 10'd0);
		key_scan(8'h29, 1'b1, " ", 10'd0);
		key_scan(8'h07, 1'b1, 8'h00, 10'd0);       // Not in the table
		key_scan(8'h55, 1'b1, "=", 10'b0000010000); // Keyboard wins
		key_pad(10'd0, 10'd0, 8'h00);
		key_pad(10'b0000100000, 10'b0000000100, "3");
		key_pad(10'd0, 10'd0, 8'h00);
		key_pad(10'b1000000000, 10'd0, "0");
		key_pad(10'd0, 10'd0, 8'h00);
		// Pad 0 holds right, up and action while pad 1 holds left and down
		@(posedge clk_sys);
		joy0 <= 16'h0019;
		joy1 <= 16'h0006;
		@(negedge clk_sys);
		assert (joy_lines == 10'b01_10_10_01_01) else
			report_mismatch("joy_o", joy_lines, 10'b01_10_10_01_01);
		@(posedge clk_sys);
		joy_swap_i <= 1'b1;
		@(negedge clk_sys);
		assert (joy_lines == 10'b10_01_01_10_10) else
			report_mismatch("joy_o", joy_lines, 10'b10_01_01_10_10);
		end_test("key events and pads", e);

		e = errors;
		c8n = 24'h790000;
		c8p = 24'hB60000;
		for (int m = 0; m < 2; m++) begin
			colour_check(4'd0, 1'b0, m[0], 24'h000000);
			colour_check(4'd0, 1'b1, m[0], 24'h000000);
			colour_check(4'd8, 1'b0, m[0], c8n);
			colour_check(4'd8, 1'b1, m[0], c8p);
			colour_check(4'd15, 1'b0, m[0], 24'hFFFFFF);
			colour_check(4'd15, 1'b1, m[0], 24'hFFFFFF);
		end
		end_test("palette", e);

		$display("tests run: %0d, tests failed: %0d, failed checks: %0d", tests_run,
			tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/vp_glue_top.sv
// Board glue for an external console core; clk_sys comes from outside and no PLL is included
`default_nettype none

module vp_glue_top (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                pal_i,         // Timing standard, PAL when high
	input  wire                pal_palette_i,
	input  wire                mono_i,
	input  wire                joy_swap_i,
	input  vp_pkg::dl_bus_t    dl_i,
	input  vp_pkg::cart_bus_t  cart_i,
	input  wire  [15:0]        joy0_i,
	input  wire  [15:0]        joy1_i,
	input  wire  [10:0]        ps2_key_i,
	input  vp_pkg::pix_code_t  pix_i,
	output logic               cpu_en_o,
	output logic               vdc_en_o,
	output vp_pkg::byte_t      rom_data_o,
	output vp_pkg::joy_lines_t joy_o,
	output vp_pkg::key_evt_t   key_evt_o,
	output vp_pkg::rgb24_t     rgb_o,
	output logic               console_res_n_o
);

	logic pad_reset;

	//////////////////////////////////////////////////
	// Console reset
	//////////////////////////////////////////////////
	// Core held in reset while an image loads
	assign console_res_n_o = ~(reset | dl_i.active | pad_reset);

	clk_enable_gen u_clk_en (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	cart_store u_cart (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_i       (dl_i),
		.cart_i     (cart_i),
		.rom_data_o (rom_data_o)
	);

	input_encoder u_input (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.joy_swap_i  (joy_swap_i),
		.joy0_i      (joy0_i),
		.joy1_i      (joy1_i),
		.ps2_key_i   (ps2_key_i),
		.joy_o       (joy_o),
		.pad_reset_o (pad_reset),
		.key_evt_o   (key_evt_o)
	);

	palette_map u_palette (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.pix_i         (pix_i),
		.pal_palette_i (pal_palette_i),
		.mono_i        (mono_i),
		.rgb_o         (rgb_o)
	);

endmodule

`default_nettype wire

// File: logic/palette_map.sv
// Palettes are fixed calibrated tables; greyscale uses integer weights and rounds down
`default_nettype none

module palette_map (
	input  wire               clk_sys,
	input  wire               reset,
	input  vp_pkg::pix_code_t pix_i,
	input  wire               pal_palette_i,
	input  wire               mono_i,
	output vp_pkg::rgb24_t    rgb_o
);

	import vp_pkg::*;

	// Index is {r, g, b, luma}
	localparam rgb24_t ntsc_lut [16] = '{
		24'h000000, 24'h676767, // Black
		24'h1A37BE, 24'h5C80F6, // Blue
		24'h006D07, 24'h56C469, // Green
		24'h2AAABE, 24'h77E6EB, // Cyan
		24'h790000, 24'hC75151, // Red
		24'h94309F, 24'hDC84E8, // Magenta
		24'h77670B, 24'hC6B86A, // Yellow
		24'hCECECE, 24'hFFFFFF  // White
	};

	localparam rgb24_t pal_lut [16] = '{
		24'h000000, 24'h494949,
		24'h0000B6, 24'h4949FF,
		24'h00B601, 24'h49FF49,
		24'h00B6C9, 24'h49FFFF,
		24'hB60000, 24'hFF4949,
		24'hB600B6, 24'hFF49FF,
		24'hB6B600, 24'hFFFF49,
		24'hB6B6B6, 24'hFFFFFF
	};

	logic [3:0]  code;
	rgb24_t      colour;
	logic [15:0] luma_sum;
	byte_t       grey;

	assign code   = pix_i;
	assign colour = pal_palette_i ? pal_lut[code] : ntsc_lut[code];

	// Y = (77 R + 150 G + 29 B) / 256
	assign luma_sum = 16'd77 * colour.r + 16'd150 * colour.g + 16'd29 * colour.b;
	assign grey     = luma_sum[15:8];

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o <= '0;
		end else if (mono_i) begin
			rgb_o.r <= grey;
			rgb_o.g <= grey;
			rgb_o.b <= grey;
		end else begin
			rgb_o <= colour;
		end
	end

endmodule

`default_nettype wire

// File: logic/input_encoder.sv
// Key events are single-cycle strobes with no back-pressure; keyboard wins over numpad
`default_nettype none

module input_encoder (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                joy_swap_i,
	input  wire  [15:0]        joy0_i,
	input  wire  [15:0]        joy1_i,
	input  wire  [10:0]        ps2_key_i,
	output vp_pkg::joy_lines_t joy_o,
	output logic               pad_reset_o,
	output vp_pkg::key_evt_t   key_evt_o
);

	import vp_pkg::*;

	// Pad bit 0 is right, 1 left, 2 down, 3 up, 4 action, 5 reset and 15..6 the numpad
	logic [15:0] joy_a;
	logic [15:0] joy_b;
	logic [9:0]  numpad;
	logic [9:0]  numpad_q;
	logic        key_tog_q;
	logic        kbd_event;
	logic        pad_event;

	// PS/2 set 2 scan code to the ASCII the keymap expects
	function automatic byte_t scan_to_ascii(input byte_t code);
		case (code)
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h45: return "0";
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			8'h5A: return 8'd10;  // Enter
			8'h66: return 8'd8;   // Backspace
			8'h1F: return 8'h11;  // Left GUI as yes
			8'h27: return 8'h12;  // Right GUI as no
			default: return 8'h00;
		endcase
	endfunction

	// Lowest pressed button wins and bit 9 is the zero key
	function automatic byte_t numpad_digit(input logic [9:0] pads);
		byte_t digit;
		digit = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (pads[i]) begin
				digit = (i == 9) ? "0" : byte_t'(8'h31 + i);
			end
		end
		return digit;
	endfunction

	//////////////////////////////////////////////////
	// Pads
	//////////////////////////////////////////////////
	assign joy_a = joy_swap_i ? joy1_i : joy0_i;
	assign joy_b = joy_swap_i ? joy0_i : joy1_i;

	assign joy_o.up_n     = {~joy_a[3], ~joy_b[3]};
	assign joy_o.down_n   = {~joy_a[2], ~joy_b[2]};
	assign joy_o.left_n   = {~joy_a[1], ~joy_b[1]};
	assign joy_o.right_n  = {~joy_a[0], ~joy_b[0]};
	assign joy_o.action_n = {~joy_a[4], ~joy_b[4]};

	assign pad_reset_o = joy_a[5] | joy_b[5];
	assign numpad      = joy_a[15:6] | joy_b[15:6];

	//////////////////////////////////////////////////
	// Key events
	//////////////////////////////////////////////////
	// Previous toggle bit and numpad state for edge detection
	always_ff @(posedge clk_sys) begin
		key_tog_q <= ps2_key_i[10];
		numpad_q  <= numpad;
	end

	assign kbd_event = ps2_key_i[10] != key_tog_q;
	assign pad_event = numpad != numpad_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_evt_o <= '0;
		end else begin
			key_evt_o.strobe <= kbd_event | pad_event;
			if (kbd_event) begin
				key_evt_o.ascii    <= scan_to_ascii(ps2_key_i[7:0]);
				key_evt_o.released <= ~ps2_key_i[9];
			end else if (pad_event) begin
				key_evt_o.ascii    <= numpad_digit(numpad);
				key_evt_o.released <= numpad == 10'd0; // Last button let go
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/cart_store.sv
// Bytes must arrive in address order from the start of a download; read data has one cycle latency
`default_nettype none

`include "vp_cfg.svh"

module cart_store (
	input  wire               clk_sys,
	input  wire               reset,
	input  vp_pkg::dl_bus_t   dl_i,
	input  vp_pkg::cart_bus_t cart_i,
	output vp_pkg::byte_t     rom_data_o
);

	import vp_pkg::*;

	byte_t     mem [`VP_ROM_DEPTH];
	logic      active_q;
	logic      dl_start;
	logic      dl_write;
	img_size_t img_size;
	logic      xrom;
	rom_addr_t wr_addr;
	rom_addr_t rd_addr;
	map_mode_t map_mode;

	//////////////////////////////////////////////////
	// Download tracking
	//////////////////////////////////////////////////
	assign dl_start = dl_i.active & ~active_q;
	assign dl_write = dl_i.active & dl_i.wr & (dl_i.index < `VP_IDX_FONT); // Font is ignored

	// First byte may come on the start cycle itself
	assign wr_addr = dl_start ? '0 : img_size[`VP_ROM_AW-1:0];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			active_q <= 1'b0;
			img_size <= '0;
			xrom     <= 1'b0;
		end else begin
			active_q <= dl_i.active;
			if (dl_start) begin
				img_size <= dl_write ? 16'd1 : 16'd0;
				xrom     <= dl_i.index == `VP_IDX_XROM;
			end else if (dl_write) begin
				img_size <= img_size + 16'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Bank mapping
	//////////////////////////////////////////////////
	always_comb begin
		if (xrom) begin
			map_mode = MAP_XROM;
		end else begin
			case (img_size)
				`VP_SIZE_4K:  map_mode = MAP_4K;
				`VP_SIZE_8K:  map_mode = MAP_8K;
				`VP_SIZE_16K: map_mode = MAP_16K;
				default:      map_mode = MAP_2K; // Odd sizes run as plain 2K
			endcase
		end
	end

	always_comb begin
		unique case (map_mode)
			MAP_XROM: rd_addr = {2'b00, cart_i.addr};
			MAP_4K:   rd_addr = {2'b00, cart_i.bs0, cart_i.addr[11], cart_i.addr[9:0]};
			MAP_8K:   rd_addr = {1'b0, cart_i.bs1, cart_i.bs0, cart_i.addr[11], cart_i.addr[9:0]};
			MAP_16K:  rd_addr = {cart_i.bs1, cart_i.bs0, cart_i.addr};
			default:  rd_addr = {3'b000, cart_i.addr[11], cart_i.addr[9:0]}; // A10 not decoded
		endcase
	end

	//////////////////////////////////////////////////
	// Byte memory
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (dl_write) begin
			mem[wr_addr] <= dl_i.data;
		end
		if (!cart_i.psen_n) begin
			rom_data_o <= mem[rd_addr]; // Holds while PSEN is high
		end
	end

endmodule

`default_nettype wire

// File: logic/clk_enable_gen.sv
// Enables are single clk_sys pulses; a pal_i change restarts both periods from zero
`default_nettype none

`include "vp_cfg.svh"

module clk_enable_gen (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	logic [3:0] cpu_cnt;
	logic [3:0] vdc_cnt;
	logic [3:0] cpu_last; // Terminal count for the current standard
	logic [3:0] vdc_last;
	logic       pal_q;
	logic       pal_changed;

	assign cpu_last = pal_i ? 4'(`VP_CPU_DIV_PAL - 1) : 4'(`VP_CPU_DIV_NTSC - 1);
	assign vdc_last = pal_i ? 4'(`VP_VDC_DIV_PAL - 1) : 4'(`VP_VDC_DIV_NTSC - 1);

	// Standard seen on the previous clock
	always_ff @(posedge clk_sys) begin
		pal_q <= pal_i;
	end

	assign pal_changed = pal_q != pal_i;

	//////////////////////////////////////////////////
	// Wrap-around dividers
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt  <= 4'd0;
			vdc_cnt  <= 4'd0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else if (pal_changed) begin
			cpu_cnt  <= 4'd0; // Restart on a standard switch
			vdc_cnt  <= 4'd0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			if (cpu_cnt >= cpu_last) begin
				cpu_cnt  <= 4'd0;
				cpu_en_o <= 1'b1;
			end else begin
				cpu_cnt  <= cpu_cnt + 4'd1;
				cpu_en_o <= 1'b0;
			end

			if (vdc_cnt >= vdc_last) begin
				vdc_cnt  <= 4'd0;
				vdc_en_o <= 1'b1;
			end else begin
				vdc_cnt  <= vdc_cnt + 4'd1;
				vdc_en_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/vp_pkg.sv
// Shared types of the console glue; field order of the structs follows the console pin order
`default_nettype none

`include "vp_cfg.svh"

package vp_pkg;

	typedef logic [7:0]            byte_t;
	typedef logic [11:0]           cart_addr_t;
	typedef logic [`VP_ROM_AW-1:0] rom_addr_t;
	typedef logic [15:0]           img_size_t;
	typedef logic [7:0]            dl_index_t;

	typedef struct packed {
		byte_t r;
		byte_t g;
		byte_t b;
	} rgb24_t;

	// Pixel code as the VDC emits it, r on top
	typedef struct packed {
		logic r;
		logic g;
		logic b;
		logic luma;
	} pix_code_t;

	typedef struct packed {
		logic      active;
		logic      wr;     // One-cycle strobe
		dl_index_t index;
		byte_t     data;
	} dl_bus_t;

	typedef struct packed {
		cart_addr_t addr;
		logic       bs0;
		logic       bs1;
		logic       psen_n;
		logic       cs_n;
	} cart_bus_t;

	// Bit 1 is the first pad after the swap
	typedef struct packed {
		logic [1:0] up_n;
		logic [1:0] down_n;
		logic [1:0] left_n;
		logic [1:0] right_n;
		logic [1:0] action_n;
	} joy_lines_t;

	typedef struct packed {
		logic  strobe;
		byte_t ascii;
		logic  released;
	} key_evt_t;

	typedef enum logic [2:0] {
		MAP_XROM,
		MAP_2K,
		MAP_4K,
		MAP_8K,
		MAP_16K
	} map_mode_t;

endpackage

`default_nettype wire

// File: logic/vp_cfg.svh
// Fixed console constants; divider counts assume clk_sys at the NTSC or PAL system clock rate
`ifndef VP_CFG_SVH
`define VP_CFG_SVH

//////////////////////////////////////////////////
// Clock-enable periods in clk_sys cycles
//////////////////////////////////////////////////
`define VP_CPU_DIV_NTSC 8
`define VP_CPU_DIV_PAL  12
`define VP_VDC_DIV_NTSC 6
`define VP_VDC_DIV_PAL  10

//////////////////////////////////////////////////
// Cartridge store
//////////////////////////////////////////////////
`define VP_ROM_AW    14
`define VP_ROM_DEPTH (1 << `VP_ROM_AW)

// Image byte counts that pick a bank mapping
`define VP_SIZE_4K  16'h1000
`define VP_SIZE_8K  16'h2000
`define VP_SIZE_16K 16'h4000

// Download file indices
`define VP_IDX_XROM 8'd2
`define VP_IDX_FONT 8'd3

`endif
